/* source/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // Byte address and data word of the 16-bit processor
    typedef logic [15:0] addr_t;
    typedef logic [15:0] data_t;

    // Block geometry
    localparam int WORDS_PER_BLOCK = 8;
    localparam int OFFSET_BITS     = 3;

    // Word count within one block fill, wide enough to reach 8
    typedef logic [3:0] word_cnt_t;

    // Miss controller states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_I,
        WAIT_D,
        WAIT_WB
    } fill_state_t;

endpackage

`default_nettype wire

/* source/cache_array.sv */
`default_nettype none

module cache_array #(
    parameter int NUM_LINES = 16
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire cache_pkg::addr_t     addr,
    output logic                      hit,
    output cache_pkg::data_t          rdata,
    input  wire logic                 fill_we,
    input  wire cache_pkg::word_cnt_t fill_offset,
    input  wire cache_pkg::data_t     fill_data,
    input  wire logic                 tag_we,
    input  wire logic                 store_we,
    input  wire cache_pkg::data_t     store_data
);

    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_LSB    = cache_pkg::OFFSET_BITS + 1 + INDEX_BITS;
    localparam int TAG_BITS   = $bits(cache_pkg::addr_t) - TAG_LSB;

    logic [cache_pkg::OFFSET_BITS-1:0] offset;
    logic [INDEX_BITS-1:0]             index;
    logic [TAG_BITS-1:0]               tag;

    cache_pkg::data_t     data_mem [NUM_LINES][cache_pkg::WORDS_PER_BLOCK];
    logic [TAG_BITS-1:0]  tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid;

    // Address split, bit 0 is the byte within the word
    assign offset = addr[cache_pkg::OFFSET_BITS:1];
    assign index  = addr[TAG_LSB-1 -: INDEX_BITS];
    assign tag    = addr[$bits(cache_pkg::addr_t)-1:TAG_LSB];

    // Combinational lookup
    assign hit   = valid[index] && (tag_mem[index] == tag);
    assign rdata = data_mem[index][offset];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (tag_we) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[index][fill_offset[cache_pkg::OFFSET_BITS-1:0]] <= fill_data;
        end else if (store_we && hit) begin
            // Write-through store, no allocate on a miss
            data_mem[index][offset] <= store_data;
        end
        if (tag_we) begin
            tag_mem[index] <= tag;
        end
    end

    // Stores are only let through while the controller is idle
    a_no_fill_store_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(fill_we && store_we)
    );

endmodule

`default_nettype wire

/* source/fill_ctrl.sv */
`default_nettype none

module fill_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 i_miss,
    input  wire logic                 d_miss,
    input  wire cache_pkg::addr_t     i_addr,
    input  wire cache_pkg::addr_t     d_addr,
    input  wire logic                 mem_rvalid,
    output logic                      mem_en,
    output cache_pkg::addr_t          mem_addr,
    output logic                      fill_we_i,
    output logic                      fill_we_d,
    output logic                      tag_we_i,
    output logic                      tag_we_d,
    output cache_pkg::word_cnt_t      fill_offset,
    output logic                      stall,
    output logic                      idle
);

    cache_pkg::fill_state_t state;
    cache_pkg::fill_state_t next_state;

    cache_pkg::word_cnt_t issue_cnt;
    cache_pkg::word_cnt_t ret_cnt;
    cache_pkg::addr_t     addr_reg;

    logic filling;
    logic last_word;

    // First word address of the block holding a
    function automatic cache_pkg::addr_t block_base(cache_pkg::addr_t a);
        cache_pkg::addr_t base;
        base = a;
        base[cache_pkg::OFFSET_BITS:0] = '0;
        return base;
    endfunction

    //////////////////////////////
    // Request issue and returns
    //////////////////////////////

    assign filling   = (state == cache_pkg::WAIT_I) || (state == cache_pkg::WAIT_D);
    assign last_word = filling && mem_rvalid &&
                       (ret_cnt == cache_pkg::word_cnt_t'(cache_pkg::WORDS_PER_BLOCK - 1));

    // One read per cycle until the whole block is requested
    assign mem_en   = filling && (issue_cnt < cache_pkg::WORDS_PER_BLOCK);
    assign mem_addr = addr_reg;

    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE) begin
            addr_reg <= block_base(i_miss ? i_addr : d_addr);
        end else if (last_word) begin
            // Next block is the data side, if it is still missing
            addr_reg <= block_base(d_addr);
        end else if (mem_en) begin
            addr_reg <= addr_reg + 16'd2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            if (!filling || last_word) begin
                issue_cnt <= '0;
            end else if (mem_en) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            // Counts words as they come back, whatever the memory latency
            if (!filling || last_word) begin
                ret_cnt <= '0;
            end else if (mem_rvalid) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::IDLE: begin
                if (i_miss) begin
                    next_state = cache_pkg::WAIT_I;
                end else if (d_miss) begin
                    next_state = cache_pkg::WAIT_D;
                end
            end
            cache_pkg::WAIT_I: begin
                if (last_word) begin
                    next_state = d_miss ? cache_pkg::WAIT_D : cache_pkg::WAIT_WB;
                end
            end
            cache_pkg::WAIT_D: begin
                if (last_word) begin
                    next_state = cache_pkg::WAIT_WB;
                end
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    // Fill writes go to the cache that missed
    assign fill_we_i   = mem_rvalid && (state == cache_pkg::WAIT_I);
    assign fill_we_d   = mem_rvalid && (state == cache_pkg::WAIT_D);
    assign tag_we_i    = last_word && (state == cache_pkg::WAIT_I);
    assign tag_we_d    = last_word && (state == cache_pkg::WAIT_D);
    assign fill_offset = ret_cnt;

    assign idle  = (state == cache_pkg::IDLE);
    assign stall = !idle || i_miss || d_miss;

    a_no_rvalid_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == cache_pkg::IDLE) |-> !mem_rvalid
    );

    // Whole block requested before its last word returns
    a_block_issued_before_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        last_word |-> (issue_cnt == cache_pkg::WORDS_PER_BLOCK)
    );

endmodule

`default_nettype wire

/* source/main_memory.sv */
`default_nettype none

module main_memory #(
    parameter int MEM_LATENCY = 4,
    parameter int MEM_WORDS   = 1024
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             en,
    input  wire cache_pkg::addr_t addr,
    input  wire logic             we,
    input  wire cache_pkg::data_t wdata,
    output logic                  rvalid,
    output cache_pkg::data_t      rdata
);

    cache_pkg::data_t       mem [MEM_WORDS];
    cache_pkg::data_t       data_pipe [MEM_LATENCY];
    logic [MEM_LATENCY-1:0] valid_pipe;
    int                     word_idx;

    // Word address, wrapped to the array size
    assign word_idx = int'(addr[15:1]) % MEM_WORDS;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_idx] <= wdata;
        end
    end

    // Read pipeline, one stage per cycle of latency
    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[word_idx];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= en;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign rvalid = valid_pipe[MEM_LATENCY-1];
    assign rdata  = data_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

/* source/cache_system.sv */
`default_nettype none

module cache_system #(
    parameter int NUM_LINES   = 16,
    parameter int MEM_LATENCY = 4,
    parameter int MEM_WORDS   = 1024
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             i_req,
    input  wire cache_pkg::addr_t i_addr,
    output cache_pkg::data_t      i_data,
    input  wire logic             d_rd,
    input  wire logic             d_wr,
    input  wire cache_pkg::addr_t d_addr,
    input  wire cache_pkg::data_t d_wdata,
    output cache_pkg::data_t      d_rdata,
    output logic                  stall
);

    logic                 i_hit;
    logic                 d_hit;
    logic                 i_miss;
    logic                 d_miss;
    logic                 idle;
    logic                 fill_we_i;
    logic                 fill_we_d;
    logic                 tag_we_i;
    logic                 tag_we_d;
    cache_pkg::word_cnt_t fill_offset;
    logic                 mem_en;
    logic                 mem_we;
    cache_pkg::addr_t     mem_addr;
    cache_pkg::addr_t     mem_port_addr;
    logic                 mem_rvalid;
    cache_pkg::data_t     mem_rdata;

    //////////////////////////////
    // Miss and store glue
    //////////////////////////////

    assign i_miss = i_req && !i_hit;
    assign d_miss = d_rd && !d_hit;

    // Store goes through only in an accepted cycle
    assign mem_we = d_wr && !stall && idle;

    // Fill reads and stores never share a cycle
    assign mem_port_addr = idle ? d_addr : mem_addr;

    cache_array #(
        .NUM_LINES   (NUM_LINES)
    ) icache (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (i_addr),
        .hit         (i_hit),
        .rdata       (i_data),
        .fill_we     (fill_we_i),
        .fill_offset (fill_offset),
        .fill_data   (mem_rdata),
        .tag_we      (tag_we_i),
        .store_we    (1'b0),
        .store_data  ('0)
    );

    cache_array #(
        .NUM_LINES   (NUM_LINES)
    ) dcache (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (d_addr),
        .hit         (d_hit),
        .rdata       (d_rdata),
        .fill_we     (fill_we_d),
        .fill_offset (fill_offset),
        .fill_data   (mem_rdata),
        .tag_we      (tag_we_d),
        .store_we    (mem_we),
        .store_data  (d_wdata)
    );

    fill_ctrl fill_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_miss      (i_miss),
        .d_miss      (d_miss),
        .i_addr      (i_addr),
        .d_addr      (d_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_en      (mem_en),
        .mem_addr    (mem_addr),
        .fill_we_i   (fill_we_i),
        .fill_we_d   (fill_we_d),
        .tag_we_i    (tag_we_i),
        .tag_we_d    (tag_we_d),
        .fill_offset (fill_offset),
        .stall       (stall),
        .idle        (idle)
    );

    main_memory #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_WORDS   (MEM_WORDS)
    ) main_memory_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (mem_en),
        .addr        (mem_port_addr),
        .we          (mem_we),
        .wdata       (d_wdata),
        .rvalid      (mem_rvalid),
        .rdata       (mem_rdata)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_cache_system.sv */
`default_nettype none

module tb_cache_system;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD      = 8;
    localparam int          RESET_CYCLES    = 4;
    localparam int          SAMPLE_DELAY    = 2;
    localparam int          CYCLES_PER_LINE = 60;
    localparam int          NUM_LINES       = 16;
    localparam int          BLOCK_BYTES     = 16;
    localparam int          FILL_WORDS      = 8;
    localparam int          SHADOW_WORDS    = 1024;
    localparam logic [31:0] RANDOM_SEED     = 32'hd0f0_050a;
    localparam string       ACCESS_FILE     = "testbench/access_input.txt";

    logic        clk;
    logic        rst_n;
    logic        i_req;
    logic [15:0] i_addr;
    logic [15:0] i_data;
    logic        d_rd;
    logic        d_wr;
    logic [15:0] d_addr;
    logic [15:0] d_wdata;
    logic [15:0] d_rdata;
    logic        stall;

    // Access list as read from the file
    logic [7:0]  acc_port [$];
    logic [7:0]  acc_op [$];
    logic [15:0] acc_addr [$];
    logic [15:0] acc_data [$];

    // Reference state: memory contents and which blocks each cache holds
    logic [15:0] shadow [SHADOW_WORDS];
    bit          i_line_valid [NUM_LINES];
    int          i_line_tag [NUM_LINES];
    bit          d_line_valid [NUM_LINES];
    int          d_line_tag [NUM_LINES];

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cache_system #(
        .NUM_LINES   (NUM_LINES),
        .MEM_LATENCY (4),
        .MEM_WORDS   (SHADOW_WORDS)
    ) cache_system_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (i_req),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .d_rd    (d_rd),
        .d_wr    (d_wr),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .stall   (stall)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at time %0t: %s is 0x%h, expected 0x%h",
                     $time, name, actual, expected);
        end
    endtask

    function automatic int line_index(logic [15:0] a);
        return (int'(a) / BLOCK_BYTES) % NUM_LINES;
    endfunction

    function automatic int line_tag(logic [15:0] a);
        return int'(a) / (BLOCK_BYTES * NUM_LINES);
    endfunction

    function automatic int word_index(logic [15:0] a);
        return (int'(a) / 2) % SHADOW_WORDS;
    endfunction

    // Direct-mapped lookup against the blocks filled so far
    function automatic bit predict_miss(bit is_i, logic [15:0] a);
        bit hit;
        if (is_i) begin
            hit = i_line_valid[line_index(a)] && (i_line_tag[line_index(a)] == line_tag(a));
        end else begin
            hit = d_line_valid[line_index(a)] && (d_line_tag[line_index(a)] == line_tag(a));
        end
        return !hit;
    endfunction

    function automatic void record_fill(bit is_i, logic [15:0] a);
        if (is_i) begin
            i_line_valid[line_index(a)] = 1'b1;
            i_line_tag[line_index(a)]   = line_tag(a);
        end else begin
            d_line_valid[line_index(a)] = 1'b1;
            d_line_tag[line_index(a)]   = line_tag(a);
        end
    endfunction

    task automatic clear_inputs();
        i_req   = 1'b0;
        i_addr  = '0;
        d_rd    = 1'b0;
        d_wr    = 1'b0;
        d_addr  = '0;
        d_wdata = '0;
    endtask

    task automatic load_accesses();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [7:0]  port_c;
        logic [7:0]  op_c;
        logic [15:0] addr_v;
        logic [15:0] data_v;
        fd = $fopen(ACCESS_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("Cannot open the access list %s", ACCESS_FILE);
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                line_no++;
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h", port_c, op_c, addr_v, data_v);
                    if (n == 4) begin
                        acc_port.push_back(port_c);
                        acc_op.push_back(op_c);
                        acc_addr.push_back(addr_v);
                        acc_data.push_back(data_v);
                    end else if (n > 0) begin
                        error_count++;
                        $display("Line %0d of the access list cannot be read", line_no);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Drive on the falling edge, hold until a cycle with stall low
    task automatic issue_and_wait(input bit use_i, input bit use_rd, input bit use_wr,
                                  input logic [15:0] ia, input logic [15:0] da,
                                  input logic [15:0] wdata, output int stall_cycles,
                                  output bit first_stall, output logic [15:0] i_seen,
                                  output logic [15:0] d_seen);
        @(negedge clk);
        i_req   = use_i;
        i_addr  = ia;
        d_rd    = use_rd;
        d_wr    = use_wr;
        d_addr  = da;
        d_wdata = wdata;
        stall_cycles = 0;
        #SAMPLE_DELAY;
        first_stall = stall;
        while (stall) begin
            stall_cycles++;
            @(negedge clk);
            #SAMPLE_DELAY;
        end
        i_seen = i_data;
        d_seen = d_rdata;
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    //////////////////////////////
    // Access sequences
    //////////////////////////////

    task automatic run_single(input int k);
        logic [15:0] a;
        logic [15:0] v;
        logic [15:0] i_seen;
        logic [15:0] d_seen;
        int          stall_cycles;
        bit          first_stall;
        bit          is_i;
        bit          miss;
        a    = acc_addr[k];
        v    = acc_data[k];
        is_i = (acc_port[k] == "I");
        if (acc_port[k] == "D" && acc_op[k] == "W") begin
            issue_and_wait(0, 0, 1, '0, a, v, stall_cycles, first_stall, i_seen, d_seen);
            // Controller is back in IDLE, so the store is taken at once
            check_value("stall", first_stall, 1'b0);
            shadow[word_index(a)] = v;
        end else if (acc_op[k] == "R" && (is_i || acc_port[k] == "D")) begin
            miss = predict_miss(is_i, a);
            if (is_i) begin
                issue_and_wait(1, 0, 0, a, '0, '0, stall_cycles, first_stall, i_seen, d_seen);
            end else begin
                issue_and_wait(0, 1, 0, '0, a, '0, stall_cycles, first_stall, i_seen, d_seen);
            end
            check_value("stall", first_stall, miss);
            if (miss) begin
                check_value("stall long enough for a fill", stall_cycles >= FILL_WORDS, 1'b1);
                record_fill(is_i, a);
            end
            check_value("access list value", v, shadow[word_index(a)]);
            if (is_i) begin
                check_value("i_data", i_seen, v);
            end else begin
                check_value("d_rdata", d_seen, v);
            end
        end else begin
            error_count++;
            $display("Access %0d is not an instruction read, data read or data write", k);
        end
    endtask

    // Instruction and data reads presented in the same cycle
    task automatic run_double_read(input int k);
        logic [15:0] ia;
        logic [15:0] da;
        logic [15:0] i_seen;
        logic [15:0] d_seen;
        int          stall_cycles;
        bit          first_stall;
        bit          i_miss_exp;
        bit          d_miss_exp;
        ia = acc_addr[k];
        da = acc_addr[k + 1];
        i_miss_exp = predict_miss(1, ia);
        d_miss_exp = predict_miss(0, da);
        issue_and_wait(1, 1, 0, ia, da, '0, stall_cycles, first_stall, i_seen, d_seen);
        check_value("stall", first_stall, i_miss_exp || d_miss_exp);
        if (i_miss_exp && d_miss_exp) begin
            check_value("one stall over both fills", stall_cycles >= 2 * FILL_WORDS, 1'b1);
        end
        if (i_miss_exp) begin
            record_fill(1, ia);
        end
        if (d_miss_exp) begin
            record_fill(0, da);
        end
        check_value("access list value", acc_data[k], shadow[word_index(ia)]);
        check_value("access list value", acc_data[k + 1], shadow[word_index(da)]);
        check_value("i_data", i_seen, acc_data[k]);
        check_value("d_rdata", d_seen, acc_data[k + 1]);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int k;
        clear_inputs();
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            i_line_valid[i] = 1'b0;
            i_line_tag[i]   = 0;
            d_line_valid[i] = 1'b0;
            d_line_tag[i]   = 0;
        end
        void'($urandom(RANDOM_SEED));
        load_accesses();
        cycle_limit = CYCLES_PER_LINE * acc_addr.size() + 2 * RESET_CYCLES + 4;

        wait (rst_n === 1'b1);
        @(negedge clk);
        #SAMPLE_DELAY;
        check_value("stall", stall, 1'b0);

        k = 0;
        while (k < acc_addr.size()) begin
            if (acc_op[k] == "J") begin
                if (k + 1 >= acc_addr.size() || acc_port[k] != "I" ||
                    acc_port[k + 1] != "D" || acc_op[k + 1] != "R") begin
                    error_count++;
                    $display("Access %0d must be an instruction read followed by a data read",
                             k);
                    k++;
                end else begin
                    run_double_read(k);
                    k += 2;
                end
            end else begin
                run_single(k);
                k++;
            end
            idle_gap(int'($urandom % 4));
        end
        idle_gap(1);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d clock cycles, the access list did not finish", cycle_count);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/access_input.txt */
# port (I or D)  op (R read, W write, J instruction read paired with the next data read)
# address (hex)  value (hex, write data for W, expected read value for R and J)
I R 0000 0000
D R 0010 0000
I R 0006 0000
D W 0100 1111
D W 0102 2222
D W 0104 3333
D W 010e 4444
I R 0100 1111
I R 0102 2222
I R 0104 3333
I R 010e 4444
I R 0106 0000
D R 0020 0000
D W 0022 abcd
D R 0022 abcd
I R 0022 abcd
D R 0020 0000
D W 0036 5a5a
D W 0248 6b6b
I J 0036 5a5a
D R 0248 6b6b
I R 0030 0000
D R 024e 0000
D W 0050 1234
D W 0150 5678
D R 0050 1234
D R 0150 5678
D W 0152 9abc
D R 0050 1234
D R 0152 9abc
I R 0150 5678
I R 0050 1234
D W 0060 cafe
D R 0060 cafe
D R 0062 0000

/* cache_system.f */
source/cache_pkg.sv
source/cache_array.sv
source/fill_ctrl.sv
source/main_memory.sv
source/cache_system.sv
testbench/tb_clock_gen.sv
testbench/tb_cache_system.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_cache_system
FILELIST   ?= cache_system.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
